//--- Bender.yml
package:
  name: ing_buffer

sources:
  - files:
      - verilog/ing_pkg.sv
      - verilog/ing_word_ram.sv
      - verilog/ing_desc_queue.sv
      - verilog/ing_buf_writer.sv
      - verilog/ing_buf_reader.sv
      - verilog/ing_buffer_top.sv
  - target: simulation
    files:
      - dv/ing_buffer_tb.sv

//--- dv/ing_buffer_tb.sv
// Runs ing_buffer_top with its default parameters, NUM_PORTS below must match them
// All checks are immediate assertions, so assertions must be enabled in the simulator
`timescale 1ns/10ps

module ing_buffer_tb;

    localparam int NUM_PORTS     = 4;
    localparam int DW            = ing_pkg::DATA_W;
    localparam int DB            = ing_pkg::DATA_BYTES;
    localparam int LW            = ing_pkg::LEN_W;
    localparam int PW            = $clog2(NUM_PORTS);
    localparam int CLK_PERIOD    = 8;
    localparam int PKTS_PER_PORT = 6;
    localparam int MAX_WORDS     = 25;
    // Outstanding words per port stay below the 63 a partition holds
    localparam int BACKLOG_WORDS = 48;
    // Back-pressured packets count twice, each port gets one slot in NUM_PORTS
    localparam int TOTAL_PKTS     = NUM_PORTS + 3 * NUM_PORTS * PKTS_PER_PORT + 4;
    localparam int TIMEOUT_CYCLES = TOTAL_PKTS * MAX_WORDS * NUM_PORTS * 4;

    logic                   ing_bus = 1'b0;
    logic                   rst;
    logic [NUM_PORTS-1:0]    port_valid;
    logic [NUM_PORTS*DW-1:0] port_data;
    logic [NUM_PORTS*DB-1:0] port_keep;
    logic [NUM_PORTS-1:0]    port_last;
    logic [NUM_PORTS-1:0]    port_ready;
    logic                   bus_valid;
    logic [DW-1:0]          bus_data;
    logic [DB-1:0]          bus_keep;
    logic                   bus_last;
    logic                   bus_ready;
    logic [PW-1:0]          bus_port;
    logic [LW-1:0]          bus_len;
    logic [NUM_PORTS-1:0]    overflow;

    // Words waiting to be driven, and words still expected on the bus
    logic [DW-1:0] tx_data [NUM_PORTS][$];
    logic [DB-1:0] tx_keep [NUM_PORTS][$];
    logic          tx_last [NUM_PORTS][$];
    logic [DW-1:0] exp_words [NUM_PORTS][$];
    int            exp_len [NUM_PORTS][$];
    int            backlog [NUM_PORTS];
    int            ovf_expect [NUM_PORTS];
    int            ovf_seen [NUM_PORTS];

    int    seed = 32'h1998_e410;
    int    ready_mode = 0;
    string test_name = "reset";
    int    mismatches = 0;
    int    other_errors = 0;
    int    timeouts = 0;
    int    pending = 0;
    int    rx_packets = 0;
    logic  rst_seen = 1'b0;

    // Scoreboard state for the packet on the bus
    bit    in_pkt = 1'b0;
    int    cur_port;
    int    word_idx;
    bit    held = 1'b0;
    logic [DW-1:0] held_data;
    logic [DB-1:0] held_keep;
    logic          held_last;
    logic [PW-1:0] held_port;
    logic [LW-1:0] held_len;

    ing_buffer_top dut0 (
        .ing_bus, .rst,
        .port_valid, .port_data, .port_keep, .port_last, .port_ready,
        .bus_valid, .bus_data, .bus_keep, .bus_last, .bus_ready,
        .bus_port, .bus_len,
        .overflow
    );

    always #(CLK_PERIOD / 2) ing_bus = ~ing_bus;

    // Bytes below len mod DB are kept, a zero remainder keeps the whole word
    function automatic logic [DB-1:0] last_keep(input int len);
        logic [DB-1:0] k;
        k = '0;
        for (int b = 0; b < DB; b++) begin
            if (len % DB == 0 || b < len % DB) begin
                k[b] = 1'b1;
            end
        end
        return k;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            mismatches++;
            $display("MISMATCH test=%s %s expected=%h actual=%h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic queue_packet(input int port, input int len, input bit survives);
        int            nwords;
        logic [DW-1:0] w;
        nwords = (len + DB - 1) / DB;
        for (int i = 0; i < nwords; i++) begin
            w = {$random(seed), $random(seed)};
            tx_data[port].push_back(w);
            tx_keep[port].push_back((i == nwords - 1) ? last_keep(len) : {DB{1'b1}});
            tx_last[port].push_back(i == nwords - 1);
            if (survives) begin
                exp_words[port].push_back(w);
            end
        end
        if (survives) begin
            exp_len[port].push_back(len);
            backlog[port] += nwords;
            pending++;
        end
    endtask

    // Random lengths of 64 to 200 bytes, paced so the partition never fills
    task automatic feed_port(input int port, input int count);
        int len;
        int nwords;
        for (int n = 0; n < count; n++) begin
            len = 64 + ($unsigned($random(seed)) % 137);
            nwords = (len + DB - 1) / DB;
            while (backlog[port] + nwords > BACKLOG_WORDS) begin
                @(negedge ing_bus);
            end
            queue_packet(port, len, 1'b1);
        end
    endtask

    task automatic send_random(input int count);
        for (int p = 0; p < NUM_PORTS; p++) begin
            fork
                automatic int port = p;
                feed_port(port, count);
            join_none
        end
        wait fork;
    endtask

    task automatic wait_drained();
        while (pending != 0) begin
            @(negedge ing_bus);
        end
    endtask

    task automatic take_word();
        int            len;
        int            last_idx;
        logic [DB-1:0] keep_exp;
        if (!in_pkt) begin
            assert (exp_len[bus_port].size() > 0) else begin
                other_errors++;
                $display("%s: packet from port %0d appeared on the bus but was never sent",
                         test_name, bus_port);
                return;
            end
            in_pkt   = 1'b1;
            cur_port = bus_port;
            word_idx = 0;
        end else begin
            check_value("bus_port inside packet", cur_port, bus_port);
        end
        len      = exp_len[cur_port][0];
        last_idx = (len + DB - 1) / DB - 1;
        keep_exp = (word_idx == last_idx) ? last_keep(len) : {DB{1'b1}};
        check_value("bus_len", len, bus_len);
        check_value("bus_data", exp_words[cur_port][0], bus_data);
        check_value("bus_keep", keep_exp, bus_keep);
        check_value("bus_last", word_idx == last_idx, bus_last);
        void'(exp_words[cur_port].pop_front());
        backlog[cur_port]--;
        word_idx++;
        if (bus_last || word_idx > last_idx) begin
            void'(exp_len[cur_port].pop_front());
            in_pkt = 1'b0;
            pending--;
            rx_packets++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatch, %0d other, %0d timeout; %0d packets received",
                 mismatches, other_errors, timeouts, rx_packets);
        if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    ////////////////////
    // Drivers

    // Each port holds its front word until the DUT takes it
    always @(posedge ing_bus) begin
        logic [NUM_PORTS-1:0] taken;
        int                   rnd;
        taken = port_valid & port_ready;
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (taken[p]) begin
                void'(tx_data[p].pop_front());
                void'(tx_keep[p].pop_front());
                void'(tx_last[p].pop_front());
            end
            port_valid[p] = (tx_data[p].size() != 0);
            if (port_valid[p]) begin
                port_data[p*DW +: DW] = tx_data[p][0];
                port_keep[p*DB +: DB] = tx_keep[p][0];
                port_last[p]          = tx_last[p][0];
            end
        end
        rnd = $random(seed);
        case (ready_mode)
            0:       bus_ready = 1'b1;
            1:       bus_ready = rnd[0];
            default: bus_ready = 1'b0;
        endcase
    end

    ////////////////////
    // Monitors

    // Outputs must read low at every edge that follows a reset edge
    always @(posedge ing_bus) begin
        if (rst_seen === 1'b1) begin
            check_value("reset bus_valid", 0, bus_valid);
            check_value("reset overflow", 0, overflow);
            check_value("reset port_ready", 0, port_ready);
        end
        rst_seen = rst;
    end

    always @(posedge ing_bus) begin
        if (rst === 1'b0) begin
            if (held) begin
                check_value("stalled bus_valid", 1, bus_valid);
                check_value("stalled bus_data", held_data, bus_data);
                check_value("stalled bus_keep", held_keep, bus_keep);
                check_value("stalled bus_last", held_last, bus_last);
                check_value("stalled bus_port", held_port, bus_port);
                check_value("stalled bus_len", held_len, bus_len);
            end
            held      = bus_valid && !bus_ready;
            held_data = bus_data;
            held_keep = bus_keep;
            held_last = bus_last;
            held_port = bus_port;
            held_len  = bus_len;
            if (bus_valid && bus_ready) begin
                take_word();
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (overflow[p]) begin
                    assert (ovf_seen[p] < ovf_expect[p]) else begin
                        other_errors++;
                        $display("%s: overflow pulse on port %0d that no packet caused",
                                 test_name, p);
                    end
                    ovf_seen[p]++;
                end
            end
        end
    end

    ////////////////////
    // Test sequence

    initial begin
        int len;
        port_valid = '0;
        port_data  = '0;
        port_keep  = '0;
        port_last  = '0;
        bus_ready  = 1'b0;
        rst        = 1'b1;
        repeat (4) @(posedge ing_bus);
        #1 rst = 1'b0;
        repeat (2) @(posedge ing_bus);

        test_name = "single";
        for (int p = 0; p < NUM_PORTS; p++) begin
            do begin
                len = 64 + ($unsigned($random(seed)) % 137);
            end while (len % DB == 0);
            queue_packet(p, len, 1'b1);
        end
        wait_drained();

        test_name = "interleave";
        send_random(PKTS_PER_PORT);
        wait_drained();

        test_name  = "backpressure";
        ready_mode = 1;
        send_random(PKTS_PER_PORT);
        wait_drained();

        // Two 25-word packets fit in port 1's partition, the third cannot
        test_name  = "overflow";
        ready_mode = 2;
        queue_packet(1, 196, 1'b1);
        queue_packet(1, 196, 1'b1);
        ovf_expect[1]++;
        queue_packet(1, 196, 1'b0);
        while (ovf_seen[1] != ovf_expect[1]) begin
            @(negedge ing_bus);
        end
        ready_mode = 0;
        wait_drained();
        queue_packet(1, 131, 1'b1);
        wait_drained();
        repeat (4) @(posedge ing_bus);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value("overflow pulse count", ovf_expect[p], ovf_seen[p]);
        end
        finish_run();
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        timeouts++;
        $display("Watchdog expired during test %s with %0d packets still expected",
                 test_name, pending);
        finish_run();
    end

endmodule

//--- list.f
verilog/ing_pkg.sv
verilog/ing_word_ram.sv
verilog/ing_desc_queue.sv
verilog/ing_buf_writer.sv
verilog/ing_buf_reader.sv
verilog/ing_buffer_top.sv
dv/ing_buffer_tb.sv

//--- verilog/ing_buf_reader.sv
// Sends one whole packet at a time, polling one queue per cycle
// Up to two words are in flight, rd_data must hold while rd_en is low
`timescale 1ns/10ps

module ing_buf_reader #(
    parameter int NUM_PORTS      = 4,
    parameter int DEPTH_PER_PORT = 64
) (
    input  logic                                        ing_bus,
    input  logic                                        rst,
    input  logic [NUM_PORTS-1:0]                        not_empty,
    input  logic [NUM_PORTS*$clog2(DEPTH_PER_PORT)-1:0] head_last_ptr,
    input  logic [NUM_PORTS*ing_pkg::LEN_W-1:0]         head_len,
    output logic [NUM_PORTS-1:0]                        pop,
    output logic [NUM_PORTS*$clog2(DEPTH_PER_PORT)-1:0] rd_ptr,
    output logic                                        rd_en,
    output logic [$clog2(NUM_PORTS*DEPTH_PER_PORT)-1:0] rd_addr,
    input  logic [ing_pkg::DATA_W-1:0]                  rd_data,
    output logic                                        bus_valid,
    output logic [ing_pkg::DATA_W-1:0]                  bus_data,
    output logic [ing_pkg::DATA_BYTES-1:0]              bus_keep,
    output logic                                        bus_last,
    input  logic                                        bus_ready,
    output logic [$clog2(NUM_PORTS)-1:0]                bus_port,
    output logic [ing_pkg::LEN_W-1:0]                   bus_len
);

    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int PTR_W  = $clog2(DEPTH_PER_PORT);

    typedef enum logic {POLL, READ} rd_state_t;

    rd_state_t         state;
    logic [PORT_W-1:0] sel;
    logic [PORT_W-1:0] sel_nxt;
    logic [PTR_W-1:0]  ptr_q [NUM_PORTS];
    logic [PTR_W-1:0]  cur_ptr;

    // Descriptor of the packet being read
    logic [PTR_W-1:0]          cur_last_ptr;
    logic [ing_pkg::LEN_W-1:0] cur_len;

    logic issue;
    logic issue_last;
    logic s0_adv;
    logic s1_adv;

    logic                      s0_valid;
    logic                      s0_last;
    logic [PORT_W-1:0]         s0_port;
    logic [ing_pkg::LEN_W-1:0] s0_len;

    assign sel_nxt    = (sel == PORT_W'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
    assign cur_ptr    = ptr_q[sel];
    assign s1_adv     = bus_ready | ~bus_valid;
    assign s0_adv     = s1_adv | ~s0_valid;
    assign issue      = (state == READ) & s0_adv;
    assign issue_last = issue & (cur_ptr == cur_last_ptr);

    assign rd_en   = issue;
    assign rd_addr = {sel, cur_ptr};
    assign pop     = (NUM_PORTS'(1) << sel) & {NUM_PORTS{issue_last}};

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            rd_ptr[i*PTR_W +: PTR_W] = ptr_q[i];
        end
    end

    ////////////////////
    // Poll and read FSM

    always_ff @(posedge ing_bus) begin
        if (rst) begin
            state <= POLL;
            sel   <= '0;
            ptr_q <= '{default: '0};
        end else begin
            case (state)
                POLL: begin
                    if (not_empty[sel]) begin
                        state <= READ;
                    end else begin
                        sel <= sel_nxt;
                    end
                end
                READ: begin
                    if (issue) begin
                        ptr_q[sel] <= cur_ptr + 1'b1;
                    end
                    // Last address issued, move on to the next port
                    if (issue_last) begin
                        state <= POLL;
                        sel   <= sel_nxt;
                    end
                end
                default: state <= POLL;
            endcase
        end
    end

    always_ff @(posedge ing_bus) begin
        if (state == POLL && not_empty[sel]) begin
            cur_last_ptr <= head_last_ptr[sel*PTR_W +: PTR_W];
            cur_len      <= head_len[sel*ing_pkg::LEN_W +: ing_pkg::LEN_W];
        end
    end

    ////////////////////
    // Output pipeline

    always_ff @(posedge ing_bus) begin
        if (rst) begin
            s0_valid  <= 1'b0;
            s0_last   <= 1'b0;
            bus_valid <= 1'b0;
            bus_last  <= 1'b0;
        end else begin
            if (s0_adv) begin
                s0_valid <= issue;
                s0_last  <= issue_last;
            end
            if (s1_adv) begin
                bus_valid <= s0_valid;
                bus_last  <= s0_last;
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        if (s0_adv) begin
            s0_port <= sel;
            s0_len  <= cur_len;
        end
        // rd_data lines up with stage 0
        if (s1_adv && s0_valid) begin
            bus_data <= rd_data;
            bus_keep <= s0_last ? ing_pkg::bytes_to_keep(s0_len) : '1;
            bus_port <= s0_port;
            bus_len  <= s0_len;
        end
    end

endmodule

//--- verilog/ing_buf_writer.sv
// Needs NUM_PORTS >= 2 so one port never owns two adjacent slots
// A partition holds DEPTH_PER_PORT-1 words, one slot stays free to tell full from empty
`timescale 1ns/10ps

module ing_buf_writer #(
    parameter int NUM_PORTS      = 4,
    parameter int DEPTH_PER_PORT = 64
) (
    input  logic                                        ing_bus,
    input  logic                                        rst,
    input  logic [NUM_PORTS-1:0]                        port_valid,
    input  logic [NUM_PORTS*ing_pkg::DATA_W-1:0]        port_data,
    input  logic [NUM_PORTS*ing_pkg::DATA_BYTES-1:0]    port_keep,
    input  logic [NUM_PORTS-1:0]                        port_last,
    output logic [NUM_PORTS-1:0]                        port_ready,
    input  logic [NUM_PORTS*$clog2(DEPTH_PER_PORT)-1:0] rd_ptr,
    output logic                                        wr_en,
    output logic [$clog2(NUM_PORTS*DEPTH_PER_PORT)-1:0] wr_addr,
    output logic [ing_pkg::DATA_W-1:0]                  wr_data,
    output logic [NUM_PORTS-1:0]                        push,
    output logic [$clog2(DEPTH_PER_PORT)-1:0]           push_last_ptr,
    output logic [ing_pkg::LEN_W-1:0]                   push_len,
    output logic [NUM_PORTS-1:0]                        overflow
);

    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int PTR_W  = $clog2(DEPTH_PER_PORT);
    localparam int WCNT_W = ing_pkg::LEN_W - ing_pkg::BYTE_SEL_W;

    // sel[0] owns the current slot, sel[1] and sel[2] follow the pipeline
    logic [PORT_W-1:0] sel [3];
    logic [PORT_W-1:0] sel_nxt;
    logic              accept;

    logic [WCNT_W-1:0] wcnt    [NUM_PORTS];
    logic [PTR_W-1:0]  wr_ptr  [NUM_PORTS];
    logic [PTR_W-1:0]  cmt_ptr [NUM_PORTS];
    logic [NUM_PORTS-1:0] drop;

    logic                          s0_valid;
    logic                          s0_last;
    logic                          s0_full;
    logic [ing_pkg::DATA_W-1:0]    s0_data;
    logic [ing_pkg::BYTE_SEL_W:0]  s0_bytes;
    logic [WCNT_W-1:0]             s0_wcnt;

    logic                 push_en;
    logic                 ovf_en;
    logic [PTR_W-1:0]     s2_ptr;
    logic [NUM_PORTS-1:0] slot2_hot;

    ////////////////////
    // Slot rotation

    assign sel_nxt = (sel[0] == PORT_W'(NUM_PORTS - 1)) ? '0 : sel[0] + 1'b1;
    assign accept  = port_valid[sel[0]] & port_ready[sel[0]];

    always_ff @(posedge ing_bus) begin
        if (rst) begin
            sel        <= '{default: '0};
            port_ready <= '0;
        end else begin
            sel[0]     <= sel_nxt;
            sel[1]     <= sel[0];
            sel[2]     <= sel[1];
            port_ready <= NUM_PORTS'(1) << sel_nxt;
        end
    end

    ////////////////////
    // Stage 0, latch the accepted word

    always_ff @(posedge ing_bus) begin
        if (rst) begin
            s0_valid <= 1'b0;
            wcnt     <= '{default: '0};
        end else begin
            s0_valid <= accept;
            if (accept) begin
                wcnt[sel[0]] <= port_last[sel[0]] ? '0 : wcnt[sel[0]] + 1'b1;
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        s0_last  <= port_last[sel[0]];
        s0_data  <= port_data[sel[0]*ing_pkg::DATA_W +: ing_pkg::DATA_W];
        s0_bytes <= ing_pkg::keep_to_bytes(
                        port_keep[sel[0]*ing_pkg::DATA_BYTES +: ing_pkg::DATA_BYTES]);
        s0_wcnt  <= wcnt[sel[0]];
        // Writing here would make the write pointer catch up with the reader
        s0_full  <= (wr_ptr[sel[0]] + 1'b1) == rd_ptr[sel[0]*PTR_W +: PTR_W];
    end

    ////////////////////
    // Stage 1, drop or commit

    always_ff @(posedge ing_bus) begin
        if (rst) begin
            wr_en   <= 1'b0;
            push_en <= 1'b0;
            ovf_en  <= 1'b0;
            drop    <= '0;
            wr_ptr  <= '{default: '0};
            cmt_ptr <= '{default: '0};
        end else begin
            wr_en   <= 1'b0;
            push_en <= 1'b0;
            ovf_en  <= 1'b0;
            if (s0_valid) begin
                if (s0_full || drop[sel[1]]) begin
                    // Discard the rest of the packet and roll back to the last commit
                    drop[sel[1]]   <= ~s0_last;
                    wr_ptr[sel[1]] <= cmt_ptr[sel[1]];
                    ovf_en         <= s0_last;
                end else begin
                    wr_en          <= 1'b1;
                    wr_ptr[sel[1]] <= wr_ptr[sel[1]] + 1'b1;
                    if (s0_last) begin
                        push_en         <= 1'b1;
                        cmt_ptr[sel[1]] <= wr_ptr[sel[1]] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        s2_ptr   <= wr_ptr[sel[1]];
        wr_data  <= s0_data;
        push_len <= {s0_wcnt, {ing_pkg::BYTE_SEL_W{1'b0}}} + ing_pkg::LEN_W'(s0_bytes);
    end

    ////////////////////
    // Stage 2, memory write and descriptor push

    assign slot2_hot     = NUM_PORTS'(1) << sel[2];
    assign wr_addr       = {sel[2], s2_ptr};
    assign push_last_ptr = s2_ptr;
    assign push          = slot2_hot & {NUM_PORTS{push_en}};
    assign overflow      = slot2_hot & {NUM_PORTS{ovf_en}};

endmodule

//--- verilog/ing_buffer_top.sv
// DEPTH_PER_PORT must be a power of two and NUM_PORTS at least 2
// Packets shorter than MIN_PKT_BYTES may overrun a descriptor queue
`timescale 1ns/10ps

module ing_buffer_top #(
    parameter int NUM_PORTS      = 4,
    parameter int DEPTH_PER_PORT = 64,
    parameter int MIN_PKT_BYTES  = 64
) (
    input  logic                                     ing_bus,
    input  logic                                     rst,
    input  logic [NUM_PORTS-1:0]                     port_valid,
    input  logic [NUM_PORTS*ing_pkg::DATA_W-1:0]     port_data,
    input  logic [NUM_PORTS*ing_pkg::DATA_BYTES-1:0] port_keep,
    input  logic [NUM_PORTS-1:0]                     port_last,
    output logic [NUM_PORTS-1:0]                     port_ready,
    output logic                                     bus_valid,
    output logic [ing_pkg::DATA_W-1:0]               bus_data,
    output logic [ing_pkg::DATA_BYTES-1:0]           bus_keep,
    output logic                                     bus_last,
    input  logic                                     bus_ready,
    output logic [$clog2(NUM_PORTS)-1:0]             bus_port,
    output logic [ing_pkg::LEN_W-1:0]                bus_len,
    output logic [NUM_PORTS-1:0]                     overflow
);

    localparam int PTR_W         = $clog2(DEPTH_PER_PORT);
    localparam int RAM_DEPTH     = NUM_PORTS * DEPTH_PER_PORT;
    localparam int ADDR_W        = $clog2(RAM_DEPTH);
    localparam int MIN_PKT_WORDS = (MIN_PKT_BYTES + ing_pkg::DATA_BYTES - 1) / ing_pkg::DATA_BYTES;
    localparam int QUEUE_DEPTH   = DEPTH_PER_PORT / MIN_PKT_WORDS;

    logic                       wr_en;
    logic [ADDR_W-1:0]          wr_addr;
    logic [ing_pkg::DATA_W-1:0] wr_data;
    logic                       rd_en;
    logic [ADDR_W-1:0]          rd_addr;
    logic [ing_pkg::DATA_W-1:0] rd_data;

    logic [NUM_PORTS-1:0]                push;
    logic [PTR_W-1:0]                    push_last_ptr;
    logic [ing_pkg::LEN_W-1:0]           push_len;
    logic [NUM_PORTS-1:0]                pop;
    logic [NUM_PORTS-1:0]                not_empty;
    logic [NUM_PORTS*PTR_W-1:0]          head_last_ptr;
    logic [NUM_PORTS*ing_pkg::LEN_W-1:0] head_len;
    logic [NUM_PORTS*PTR_W-1:0]          rd_ptr;

    ing_buf_writer #(
        .NUM_PORTS      (NUM_PORTS),
        .DEPTH_PER_PORT (DEPTH_PER_PORT)
    ) writer0 (
        .ing_bus, .rst,
        .port_valid, .port_data, .port_keep, .port_last, .port_ready,
        .rd_ptr,
        .wr_en, .wr_addr, .wr_data,
        .push, .push_last_ptr, .push_len,
        .overflow
    );

    ing_word_ram #(
        .DEPTH (RAM_DEPTH)
    ) ram0 (
        .ing_bus,
        .wr_en, .wr_addr, .wr_data,
        .rd_en, .rd_addr, .rd_data
    );

    // One descriptor queue per port
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_queue
        ing_desc_queue #(
            .DEPTH (QUEUE_DEPTH),
            .PTR_W (PTR_W)
        ) queue0 (
            .ing_bus,
            .rst,
            .push          (push[i]),
            .push_last_ptr (push_last_ptr),
            .push_len      (push_len),
            .pop           (pop[i]),
            .not_empty     (not_empty[i]),
            .head_last_ptr (head_last_ptr[i*PTR_W +: PTR_W]),
            .head_len      (head_len[i*ing_pkg::LEN_W +: ing_pkg::LEN_W])
        );
    end

    ing_buf_reader #(
        .NUM_PORTS      (NUM_PORTS),
        .DEPTH_PER_PORT (DEPTH_PER_PORT)
    ) reader0 (
        .ing_bus, .rst,
        .not_empty, .head_last_ptr, .head_len, .pop,
        .rd_ptr, .rd_en, .rd_addr, .rd_data,
        .bus_valid, .bus_data, .bus_keep, .bus_last, .bus_ready,
        .bus_port, .bus_len
    );

endmodule

//--- verilog/ing_desc_queue.sv
// Descriptor FIFO for one port, sized so it cannot overflow
// Pushing into a full queue or popping an empty one is not guarded
`timescale 1ns/10ps

module ing_desc_queue #(
    parameter int DEPTH = 8,
    parameter int PTR_W = 6
) (
    input  logic                      ing_bus,
    input  logic                      rst,
    input  logic                      push,
    input  logic [PTR_W-1:0]          push_last_ptr,
    input  logic [ing_pkg::LEN_W-1:0] push_len,
    input  logic                      pop,
    output logic                      not_empty,
    output logic [PTR_W-1:0]          head_last_ptr,
    output logic [ing_pkg::LEN_W-1:0] head_len
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Small enough for distributed memory
    logic [PTR_W-1:0]          last_mem [DEPTH];
    logic [ing_pkg::LEN_W-1:0] len_mem  [DEPTH];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [CNT_W-1:0] count;

    always_ff @(posedge ing_bus) begin
        if (push) begin
            last_mem[wr_idx] <= push_last_ptr;
            len_mem[wr_idx]  <= push_len;
        end
    end

    always_ff @(posedge ing_bus) begin
        if (rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= (wr_idx == IDX_W'(DEPTH - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= (rd_idx == IDX_W'(DEPTH - 1)) ? '0 : rd_idx + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign not_empty     = (count != '0);
    assign head_last_ptr = last_mem[rd_idx];
    assign head_len      = len_mem[rd_idx];

endmodule

//--- verilog/ing_pkg.sv
// Shared ingress word geometry and keep-mask helpers
// Keep masks are assumed contiguous from bit 0
package ing_pkg;

    localparam int DATA_BYTES = 8;
    localparam int DATA_W     = DATA_BYTES * 8;
    localparam int MTU_BYTES  = 1500;
    localparam int LEN_W      = $clog2(MTU_BYTES + 1);
    localparam int BYTE_SEL_W = $clog2(DATA_BYTES);

    // Number of valid bytes in a word, bit 0 is always counted
    function automatic logic [BYTE_SEL_W:0] keep_to_bytes(input logic [DATA_BYTES-1:0] keep);
        logic [BYTE_SEL_W:0] n;
        n = (BYTE_SEL_W + 1)'(DATA_BYTES);
        for (int i = DATA_BYTES - 1; i >= 1; i--) begin
            if (!keep[i]) begin
                n = (BYTE_SEL_W + 1)'(i);
            end
        end
        return n;
    endfunction

    // Last-word mask from a byte length, a zero remainder means a full word
    function automatic logic [DATA_BYTES-1:0] bytes_to_keep(input logic [LEN_W-1:0] len);
        logic [DATA_BYTES-1:0] keep;
        keep = '1;
        if (len[BYTE_SEL_W-1:0] != '0) begin
            keep = ~({DATA_BYTES{1'b1}} << len[BYTE_SEL_W-1:0]);
        end
        return keep;
    endfunction

endpackage

//--- verilog/ing_word_ram.sv
// One write port, one registered read port, no reset on the contents
// rd_data holds its value while rd_en is low
`timescale 1ns/10ps

module ing_word_ram #(
    parameter int DEPTH = 256
) (
    input  logic                       ing_bus,
    input  logic                       wr_en,
    input  logic [$clog2(DEPTH)-1:0]   wr_addr,
    input  logic [ing_pkg::DATA_W-1:0] wr_data,
    input  logic                       rd_en,
    input  logic [$clog2(DEPTH)-1:0]   rd_addr,
    output logic [ing_pkg::DATA_W-1:0] rd_data
);

    logic [ing_pkg::DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge ing_bus) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port is registered so it maps onto block memory
    always_ff @(posedge ing_bus) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule
